/* sound_vectors.txt */
# M address delta | R channel select data | F name expectedLeft expectedRight
# Selects 1 start 2 count 3 loopStart 4 loopEnd 5 position 6 lastSample 7 volume 8 looping 9 playing 10 mono 11 left
F idle 0 0
F idle 0 0
M 1 100
M 2 100
M 3 100
M 4 100
R 0 1 0
R 0 2 10
R 0 7 255
R 0 10 1
R 0 9 1
F mono_ramp 199 199
F mono_ramp 398 398
F mono_ramp 597 597
M 5 2047
M 6 0
M 19 -30
M 21 -30
M 23 0
R 0 9 0
R 0 5 4
R 0 6 32000
R 0 9 1
F mono_saturate 32639 32639
R 0 9 0
R 1 1 0
R 1 2 3
R 1 7 255
R 1 11 1
R 2 1 16
R 2 2 3
R 2 7 128
R 1 9 1
R 2 9 1
F stereo 199 -30
F stereo 398 -60
M 33 10
M 34 10
M 35 10
R 3 1 32
R 3 2 100
R 3 3 0
R 3 4 3
R 3 8 1
R 3 7 255
R 3 10 1
R 3 9 1
F loop 19 19
F loop 39 39
F loop 0 0
F loop 19 19
R 3 9 0
R 3 5 0
R 3 6 0
R 3 8 0
R 3 2 2
R 3 9 1
F stop 19 19
F stop 0 0
F stop 0 0
R 0 5 0
R 0 6 30000
R 1 5 0
R 1 6 30000
R 1 2 20
R 2 1 0
R 2 5 0
R 2 6 30000
R 2 2 20
R 2 11 1
R 3 5 0
R 3 6 30000
R 3 2 20
F sum_idle 0 0
R 0 9 1
R 1 9 1
R 2 9 1
R 3 9 1
F sum_high 32767 32767
R 0 6 -30000
R 1 6 -30000
R 2 6 -30000
R 3 6 -30000
F sum_low -32768 -32768

/* files.f */
+incdir+.
audioPkg.sv
Channel.sv
RegisterDecoder.sv
DeltaMemory.sv
ChannelMixer.sv
SoundCore.sv
SoundCore_checker.sv
tb_SoundCore.sv

/* Bender.yml */
package:
  name: sound_core

export_include_dirs:
  - .

sources:
  - audioPkg.sv
  - Channel.sv
  - RegisterDecoder.sv
  - DeltaMemory.sv
  - ChannelMixer.sv
  - SoundCore.sv
  - target: test
    files:
      - SoundCore_checker.sv
      - tb_SoundCore.sv

/* tb_SoundCore.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_SoundCore;
    import audioPkg::*;

    logic                   clk;
    logic                   rst;
    logic                   lrclk;
    logic                   regWrite;
    channelIndex_t          regChannel;
    regSelect_t             regSelect;
    regData_t               regData;
    logic                   memWrite;
    logic [`MEM_ADDR_W-1:0] memAddr;
    delta_t                 memData;
    sample_t                leftOut;
    sample_t                rightOut;

    int cycleCount;
    int cycleLimit;
    int lrclkPhase;
    int frameCount;
    int writeCount;
    bit blockStart;          // Next write opens a new block after a frame check.

    SoundCore SoundCore_i (
        .clk        (clk),
        .rst        (rst),
        .lrclk      (lrclk),
        .regWrite   (regWrite),
        .regChannel (regChannel),
        .regSelect  (regSelect),
        .regData    (regData),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData),
        .leftOut    (leftOut),
        .rightOut   (rightOut)
    );

    always #4 clk = ~clk;

    // Word clock of 32 clk per frame.
    always @(posedge clk) begin
        if (lrclkPhase == 15) begin
            lrclkPhase <= 0;
            lrclk      <= #1 !lrclk;
        end else begin
            lrclkPhase <= lrclkPhase + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", cycleLimit);
            $display("Simulation FAILED");
            $fatal(1, "Stopped by timeout.");
        end
    end

    always @(posedge clk) begin
        if (SoundCore_i.SoundCore_checker_i.failCount != 0) begin
            $display("An assertion in the bound checker failed.");
            $display("Simulation FAILED");
            $fatal(1, "Assertion failure.");
        end
    end

    task automatic compareValue(input string name, input logic signed [31:0] expected,
                                input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Output mismatch.");
        end
    endtask

    // Write blocks start right after an lrclk rise, leaving a whole frame for the writes.
    task automatic waitBlockStart();
        if (blockStart) begin
            @(posedge lrclk);
            blockStart = 0;
        end
    endtask

    task automatic idleGap();
        repeat ($urandom % 2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic driveRegWrite(input int channel, input int select, input int data);
        waitBlockStart();
        regWrite   = 1'b1;
        regChannel = channelIndex_t'(channel);
        regSelect  = regSelect_t'(select);
        regData    = regData_t'(data);
        @(posedge clk);
        #1;
        regWrite   = 1'b0;
        regSelect  = REG_NONE;
        idleGap();
    endtask

    task automatic driveMemWrite(input int address, input int delta);
        waitBlockStart();
        memWrite = 1'b1;
        memAddr  = address[`MEM_ADDR_W-1:0];
        memData  = delta_t'(delta);
        @(posedge clk);
        #1;
        memWrite = 1'b0;
        idleGap();
    endtask

    task automatic checkFrame(input string name, input int expLeft, input int expRight);
        @(posedge lrclk);
        repeat (20) @(posedge clk);
        #1;
        compareValue({name, " left"}, expLeft, $signed(leftOut));
        compareValue({name, " right"}, expRight, $signed(rightOut));
        blockStart = 1;
    endtask

    task automatic replayVectors(input bit countOnly);
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        string kind;
        string name;
        string rest;
        fd = $fopen("sound_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file sound_vectors.txt.");
            $display("Simulation FAILED");
            $fatal(1, "Missing vectors.");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) break;
            if (kind == "#") begin
                n = $fgets(rest, fd);
            end else if (kind == "M") begin
                n = $fscanf(fd, "%d %d", a, b);
                writeCount++;
                if (!countOnly) driveMemWrite(a, b);
            end else if (kind == "R") begin
                n = $fscanf(fd, "%d %d %d", a, b, c);
                writeCount++;
                if (!countOnly) driveRegWrite(a, b, c);
            end else if (kind == "F") begin
                n = $fscanf(fd, "%s %d %d", name, a, b);
                frameCount++;
                if (!countOnly) checkFrame(name, a, b);
            end else begin
                $display("Unknown record kind %s in the vectors file.", kind);
                $display("Simulation FAILED");
                $fatal(1, "Bad vectors file.");
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        lrclk      = 1'b0;
        regWrite   = 1'b0;
        regChannel = '0;
        regSelect  = REG_NONE;
        regData    = '0;
        memWrite   = 1'b0;
        memAddr    = '0;
        memData    = '0;
        cycleCount = 0;
        cycleLimit = 0;
        lrclkPhase = 0;
        blockStart = 1;
        void'($urandom(32'h6868));
        replayVectors(1);
        cycleLimit = frameCount * 32 + writeCount * 8 + 200;
        frameCount = 0;
        writeCount = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        replayVectors(0);
        if (frameCount == 0) begin
            $display("No frame checks were found in the vectors file.");
            $display("Simulation FAILED");
        end else if (SoundCore_i.SoundCore_checker_i.failCount != 0) begin
            $display("An assertion in the bound checker failed.");
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* SoundCore_checker.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module SoundCore_checker (
    input logic              clk,
    input logic              rst,
    input logic              lrclk,
    input logic              regWrite,
    input audioPkg::sample_t leftOut,
    input audioPkg::sample_t rightOut
);
    logic                          lrclkQ;
    logic                          outputEvent;
    logic [`LRCLK_SETTLE_CYCLES:0] eventHistory;   // Bit k holds the event of k+1 cycles ago.
    int                            failCount;

    always_ff @(posedge clk) begin
        lrclkQ <= lrclk;
        if (rst) begin
            eventHistory <= '0;
        end else begin
            eventHistory <= {eventHistory[`LRCLK_SETTLE_CYCLES-1:0], outputEvent};
        end
    end

    assign outputEvent = (lrclk && !lrclkQ) || regWrite;   // Causes of an output update.

    resetZero: assert property (@(posedge clk)
        $fell(rst) |-> (leftOut == '0 && rightOut == '0))
        else begin
            $error("Outputs not zero after reset.");
            failCount++;
        end

    noUnknown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({leftOut, rightOut}))
        else begin
            $error("Unknown value on the outputs.");
            failCount++;
        end

    // Auto stop adds one cycle to the usual settle time.
    quietOutputs: assert property (@(posedge clk) disable iff (rst)
        ($changed(leftOut) || $changed(rightOut)) |-> (|eventHistory))
        else begin
            $error("Outputs changed without an lrclk rise or register write.");
            failCount++;
        end

endmodule

bind SoundCore SoundCore_checker SoundCore_checker_i (
    .clk      (clk),
    .rst      (rst),
    .lrclk    (lrclk),
    .regWrite (regWrite),
    .leftOut  (leftOut),
    .rightOut (rightOut)
);

`default_nettype wire

/* SoundCore.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module SoundCore (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lrclk,
    input  logic                     regWrite,
    input  audioPkg::channelIndex_t  regChannel,
    input  audioPkg::regSelect_t     regSelect,
    input  audioPkg::regData_t       regData,
    input  logic                     memWrite,
    input  logic [`MEM_ADDR_W-1:0]   memAddr,
    input  audioPkg::delta_t         memData,
    output audioPkg::sample_t        leftOut,
    output audioPkg::sample_t        rightOut
);
    import audioPkg::*;

    regSelect_t               chanSelect [`NUM_CHANNELS];
    regData_t                 chanData;
    logic                     memWriteEn;
    logic [`MEM_ADDR_W-1:0]   memWriteAddr;
    delta_t                   memWriteData;

    sampleAddr_t              sampleAddress [`NUM_CHANNELS];
    delta_t                   sampleDelta [`NUM_CHANNELS];
    sample_t                  channelSample [`NUM_CHANNELS];
    logic [`NUM_CHANNELS-1:0] channelMono;
    logic [`NUM_CHANNELS-1:0] channelLeft;

    RegisterDecoder decoder (
        .clk          (clk),
        .rst          (rst),
        .regWrite     (regWrite),
        .regChannel   (regChannel),
        .regSelect    (regSelect),
        .regData      (regData),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memData      (memData),
        .chanSelect   (chanSelect),
        .chanData     (chanData),
        .memWriteEn   (memWriteEn),
        .memWriteAddr (memWriteAddr),
        .memWriteData (memWriteData)
    );

    DeltaMemory deltaMem (
        .clk       (clk),
        .writeEn   (memWriteEn),
        .writeAddr (memWriteAddr),
        .writeData (memWriteData),
        .readAddr  (sampleAddress),
        .readDelta (sampleDelta)
    );

    for (genvar ch = 0; ch < `NUM_CHANNELS; ch++) begin : gChannel
        Channel voice (
            .clk           (clk),
            .rst           (rst),
            .lrclk         (lrclk),
            .regSelect     (chanSelect[ch]),
            .regData       (chanData),
            .sampleDelta   (sampleDelta[ch]),
            .sampleOut     (channelSample[ch]),
            .sampleAddress (sampleAddress[ch]),
            .isMono        (channelMono[ch]),
            .isLeft        (channelLeft[ch])
        );
    end

    ChannelMixer mixer (
        .clk           (clk),
        .rst           (rst),
        .channelSample (channelSample),
        .channelMono   (channelMono),
        .channelLeft   (channelLeft),
        .leftOut       (leftOut),
        .rightOut      (rightOut)
    );

endmodule

`default_nettype wire

/* ChannelMixer.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module ChannelMixer (
    input  logic                      clk,
    input  logic                      rst,
    input  audioPkg::sample_t         channelSample [`NUM_CHANNELS],
    input  logic [`NUM_CHANNELS-1:0]  channelMono,
    input  logic [`NUM_CHANNELS-1:0]  channelLeft,
    output audioPkg::sample_t         leftOut,
    output audioPkg::sample_t         rightOut
);
    import audioPkg::*;

    // Enough headroom for every channel at full scale on one side.
    localparam int SumWidth = 16 + $clog2(`NUM_CHANNELS) + 1;

    logic signed [SumWidth-1:0] leftSum;
    logic signed [SumWidth-1:0] rightSum;

    function automatic sample_t saturate(input logic signed [SumWidth-1:0] sum);
        if (sum > 32767) begin
            return 16'sh7fff;
        end else if (sum < -32768) begin
            return 16'sh8000;
        end
        return sample_t'(sum);
    endfunction

    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int ch = 0; ch < `NUM_CHANNELS; ch++) begin
            if (channelMono[ch] || channelLeft[ch]) begin
                leftSum = leftSum + channelSample[ch];
            end
            if (channelMono[ch] || !channelLeft[ch]) begin
                rightSum = rightSum + channelSample[ch];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            leftOut  <= '0;
            rightOut <= '0;
        end else begin
            leftOut  <= saturate(leftSum);
            rightOut <= saturate(rightSum);
        end
    end

endmodule

`default_nettype wire

/* DeltaMemory.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module DeltaMemory (
    input  logic                   clk,
    input  logic                   writeEn,
    input  logic [`MEM_ADDR_W-1:0] writeAddr,
    input  audioPkg::delta_t       writeData,
    input  audioPkg::sampleAddr_t  readAddr [`NUM_CHANNELS],
    output audioPkg::delta_t       readDelta [`NUM_CHANNELS]
);
    import audioPkg::*;

    delta_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // One read port per channel, addresses wrap at the memory size.
    always_comb begin
        for (int ch = 0; ch < `NUM_CHANNELS; ch++) begin
            readDelta[ch] = mem[readAddr[ch][`MEM_ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

/* RegisterDecoder.sv */
`include "audio_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module RegisterDecoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     regWrite,
    input  audioPkg::channelIndex_t  regChannel,
    input  audioPkg::regSelect_t     regSelect,
    input  audioPkg::regData_t       regData,
    input  logic                     memWrite,
    input  logic [`MEM_ADDR_W-1:0]   memAddr,
    input  audioPkg::delta_t         memData,
    output audioPkg::regSelect_t     chanSelect [`NUM_CHANNELS],
    output audioPkg::regData_t       chanData,
    output logic                     memWriteEn,
    output logic [`MEM_ADDR_W-1:0]   memWriteAddr,
    output audioPkg::delta_t         memWriteData
);
    import audioPkg::*;

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `NUM_CHANNELS; ch++) begin
            if (rst || !regWrite || regChannel != channelIndex_t'(ch)) begin
                chanSelect[ch] <= REG_NONE;
            end else begin
                chanSelect[ch] <= regSelect;
            end
        end
        memWriteEn <= memWrite && !rst;
    end

    // Payload follows its strobe by one cycle.
    always_ff @(posedge clk) begin
        chanData     <= regData;
        memWriteAddr <= memAddr;
        memWriteData <= memData;
    end

endmodule

`default_nettype wire

/* Channel.sv */
`timescale 1ns/1ns
`default_nettype none

module Channel (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lrclk,
    input  audioPkg::regSelect_t  regSelect,
    input  audioPkg::regData_t    regData,
    input  audioPkg::delta_t      sampleDelta,
    output audioPkg::sample_t     sampleOut,
    output audioPkg::sampleAddr_t sampleAddress,
    output logic                  isMono,
    output logic                  isLeft
);
    import audioPkg::*;

    sampleAddr_t startAddress;
    position_t   sampleCount;
    position_t   loopStart;
    position_t   loopEnd;
    sample_t     loopStartSample;
    volume_t     volume;

    position_t   position;
    sample_t     lastSample;
    logic        isLooping;
    logic        isPlaying;

    logic        lrclkSampled;
    logic        lrclkPrev;
    logic        lrclkRise;

    position_t          positionPlus1;
    position_t          nextPosition;
    logic               loopWrap;
    logic signed [16:0] deltaScaled;
    logic signed [16:0] sampleSum;
    sample_t            sumSaturated;
    sample_t            nextSample;
    logic signed [24:0] scaledSample;

    // Stereo data is interleaved left/right, so a stereo frame spans two words.
    assign sampleAddress = isMono ? startAddress + sampleAddr_t'(position) + 32'd1
                         : isLeft ? startAddress + {7'd0, position, 1'b0} + 32'd2
                         :          startAddress + {7'd0, position, 1'b0} + 32'd3;

    assign lrclkRise = lrclkSampled && !lrclkPrev;

    assign positionPlus1 = position + 24'd1;
    assign loopWrap      = isLooping && (positionPlus1 >= loopEnd);
    assign nextPosition  = loopWrap ? loopStart : positionPlus1;

    assign deltaScaled = {{4{sampleDelta[11]}}, sampleDelta, 1'b0};  // 2 * delta.
    assign sampleSum   = {lastSample[15], lastSample} + deltaScaled;

    always_comb begin
        if (sampleSum[16] != sampleSum[15]) begin
            sumSaturated = sampleSum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            sumSaturated = sampleSum[15:0];
        end
    end

    assign nextSample = loopWrap ? loopStartSample : sumSaturated;

    // Gain is volume/256, which always fits back into 16 bits.
    assign scaledSample = lastSample * $signed({1'b0, volume});
    assign sampleOut    = isPlaying ? sample_t'(scaledSample[23:8]) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            lrclkSampled <= 1'b0;
            lrclkPrev    <= 1'b0;
        end else begin
            lrclkSampled <= lrclk;
            lrclkPrev    <= lrclkSampled;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            position   <= '0;
            lastSample <= '0;
            isPlaying  <= 1'b0;
            isLooping  <= 1'b0;
            isMono     <= 1'b0;
            isLeft     <= 1'b0;
        end else begin
            if (lrclkRise && isPlaying) begin
                position   <= nextPosition;
                lastSample <= nextSample;
            end
            case (regSelect)
                REG_POSITION:    position   <= regData;            // Host wins over stepping.
                REG_LAST_SAMPLE: lastSample <= sample_t'(regData[15:0]);
                REG_IS_LOOPING:  isLooping  <= regData[0];
                REG_IS_PLAYING:  isPlaying  <= regData[0];
                REG_IS_MONO:     isMono     <= regData[0];
                REG_IS_LEFT:     isLeft     <= regData[0];
                default: ;
            endcase
            if (position >= sampleCount) begin
                isPlaying <= 1'b0;                                  // End of sample.
            end
        end
    end

    always_ff @(posedge clk) begin
        case (regSelect)
            REG_START_ADDRESS: startAddress <= sampleAddr_t'(regData);
            REG_SAMPLE_COUNT:  sampleCount  <= regData;
            REG_LOOP_START:    loopStart    <= regData;
            REG_LOOP_END:      loopEnd      <= regData;
            REG_VOLUME:        volume       <= regData[7:0];
            default: ;
        endcase
        if (position == loopStart) begin
            loopStartSample <= lastSample;                          // Restart value for loops.
        end
    end

endmodule

`default_nettype wire

/* audioPkg.sv */
`default_nettype none

package audioPkg;

    typedef logic signed [15:0] sample_t;
    typedef logic signed [11:0] delta_t;
    typedef logic [7:0] volume_t;        // 256 would be unity gain.
    typedef logic [23:0] position_t;
    typedef logic [31:0] sampleAddr_t;
    typedef logic [23:0] regData_t;
    typedef logic [1:0] channelIndex_t;

    typedef enum logic [3:0] {
        REG_NONE           = 4'd0,
        REG_START_ADDRESS  = 4'd1,
        REG_SAMPLE_COUNT   = 4'd2,
        REG_LOOP_START     = 4'd3,
        REG_LOOP_END       = 4'd4,
        REG_POSITION       = 4'd5,
        REG_LAST_SAMPLE    = 4'd6,
        REG_VOLUME         = 4'd7,
        REG_IS_LOOPING     = 4'd8,
        REG_IS_PLAYING     = 4'd9,
        REG_IS_MONO        = 4'd10,
        REG_IS_LEFT        = 4'd11
    } regSelect_t;

endpackage

`default_nettype wire

/* audio_defines.svh */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Channel count of the core.
`define NUM_CHANNELS 4

// Delta memory geometry.
`define MEM_ADDR_W 10
`define MEM_DEPTH 1024

// Clock cycles from an lrclk rise until leftOut and rightOut are stable.
// Input sampling, channel step and mixer register.
`define LRCLK_SETTLE_CYCLES 3

`endif
